// File: fftPkg.sv
package fftPkg;

  // fixed transform geometry
  localparam int LANES = 4;
  localparam int POINTS = 16;

  // one real or imaginary sample, signed fixed point
  typedef logic signed [15:0] sampleT;

  // twiddle component, fraction bits set by the twiddleFrac parameter
  typedef logic signed [15:0] twiddleT;

  typedef struct packed {
    sampleT re;
    sampleT im;
  } complexT;

  typedef struct packed {
    twiddleT re;
    twiddleT im;
  } twiddleCplxT;

  // one lane's four operands or results
  typedef complexT [3:0] laneVecT;

  // whole frame, indexed by sample number
  typedef complexT [POINTS-1:0] frameT;

  // rotations for lane elements 1 to 3, entry 0 belongs to element 1
  typedef twiddleCplxT [2:0] laneTwiddleT;

  typedef laneTwiddleT [LANES-1:0] twiddleSetT;

  typedef enum logic [2:0] {
    IDLE,
    STAGE1,
    XPOSE,
    STAGE2,
    UNLOAD
  } seqStateT;

  // routing command to the shuffler
  typedef enum logic [1:0] {
    OP_NONE,
    OP_LOAD,
    OP_XPOSE,
    OP_UNLOAD
  } shuffleOpT;

endpackage

// File: twiddleRotator.sv
`timescale 1ns/1ps

module twiddleRotator import fftPkg::*; #(
  parameter int twiddleFrac = 14
) (
  input  logic        clk,
  input  logic        rst,
  input  complexT     in,
  input  twiddleCplxT tw,
  input  logic        rotate,
  input  logic        valid,
  output complexT     out,
  output logic        outValid
);

  logic signed [31:0] prodReRe;
  logic signed [31:0] prodImIm;
  logic signed [31:0] prodReIm;
  logic signed [31:0] prodImRe;
  logic signed [32:0] sumRe;
  logic signed [32:0] sumIm;
  logic signed [32:0] scaledRe;
  logic signed [32:0] scaledIm;

  assign prodReRe = in.re * tw.re;
  assign prodImIm = in.im * tw.im;
  assign prodReIm = in.re * tw.im;
  assign prodImRe = in.im * tw.re;

  // full precision before the shift, truncated to sample width after
  assign sumRe = prodReRe - prodImIm;
  assign sumIm = prodReIm + prodImRe;
  assign scaledRe = sumRe >>> twiddleFrac;
  assign scaledIm = sumIm >>> twiddleFrac;

  always_ff @(posedge clk) begin
    if (rotate) begin
      out.re <= scaledRe[15:0];
      out.im <= scaledIm[15:0];
    end else begin
      out <= in;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      outValid <= 1'b0;
    end else begin
      outValid <= valid;
    end
  end

endmodule

// File: radix4Butterfly.sv
`timescale 1ns/1ps

module radix4Butterfly import fftPkg::*; #(
  parameter int twiddleFrac = 14
) (
  input  logic        clk,
  input  logic        rst,
  input  laneVecT     laneIn,
  input  laneTwiddleT twiddles,
  input  logic        laneValid,
  input  logic        rotate,
  output laneVecT     laneOut,
  output logic        laneOutValid
);

  logic signed [17:0] xRe [4];
  logic signed [17:0] xIm [4];
  laneVecT dft;
  laneVecT dftReg;
  complexT elem0Reg;
  logic validReg;
  logic rotateReg;
  logic [2:0] rotValid;

  // divide by four with floor rounding
  function automatic sampleT quarter(input logic signed [17:0] s);
    return s[17:2];
  endfunction

  always_comb begin
    for (int m = 0; m < 4; m++) begin
      xRe[m] = laneIn[m].re;
      xIm[m] = laneIn[m].im;
    end
    dft[0].re = quarter(xRe[0] + xRe[1] + xRe[2] + xRe[3]);
    dft[0].im = quarter(xIm[0] + xIm[1] + xIm[2] + xIm[3]);
    // X1 = a - jb - c + jd
    dft[1].re = quarter(xRe[0] + xIm[1] - xRe[2] - xIm[3]);
    dft[1].im = quarter(xIm[0] - xRe[1] - xIm[2] + xRe[3]);
    dft[2].re = quarter(xRe[0] - xRe[1] + xRe[2] - xRe[3]);
    dft[2].im = quarter(xIm[0] - xIm[1] + xIm[2] - xIm[3]);
    // X3 = a + jb - c - jd
    dft[3].re = quarter(xRe[0] - xIm[1] - xRe[2] + xIm[3]);
    dft[3].im = quarter(xIm[0] + xRe[1] - xIm[2] - xRe[3]);
  end

  always_ff @(posedge clk) begin
    dftReg <= dft;
    // element 0 skips rotation, delayed to line up with the rotators
    elem0Reg <= dftReg[0];
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      validReg <= 1'b0;
      rotateReg <= 1'b0;
    end else begin
      validReg <= laneValid;
      rotateReg <= rotate;
    end
  end

  for (genvar e = 1; e < 4; e++) begin : rotGen
    twiddleRotator #(
      .twiddleFrac(twiddleFrac)
    ) rot (
      .clk(clk),
      .rst(rst),
      .in(dftReg[e]),
      .tw(twiddles[e-1]),
      .rotate(rotateReg),
      .valid(validReg),
      .out(laneOut[e]),
      .outValid(rotValid[e-1])
    );
  end

  assign laneOut[0] = elem0Reg;
  assign laneOutValid = &rotValid;

endmodule

// File: stageSequencer.sv
`timescale 1ns/1ps

module stageSequencer import fftPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  logic      laneOutValid,
  output shuffleOpT shuffleOp,
  output logic      laneValid,
  output logic      rotate,
  output logic      done
);

  seqStateT state;
  seqStateT nextState;

  always_comb begin
    nextState = state;
    shuffleOp = OP_NONE;
    case (state)
      IDLE: begin
        if (start) begin
          nextState = STAGE1;
          shuffleOp = OP_LOAD;
        end
      end
      STAGE1: begin
        if (laneOutValid) begin
          nextState = XPOSE;
          shuffleOp = OP_XPOSE;
        end
      end
      // stage two operands are in flight
      XPOSE: nextState = STAGE2;
      STAGE2: begin
        if (laneOutValid) begin
          nextState = UNLOAD;
          shuffleOp = OP_UNLOAD;
        end
      end
      UNLOAD: nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= IDLE;
      laneValid <= 1'b0;
      rotate <= 1'b0;
      done <= 1'b0;
    end else begin
      state <= nextState;
      // issue a stage right after its operands are routed
      laneValid <= (shuffleOp == OP_LOAD) || (shuffleOp == OP_XPOSE);
      // only stage one is rotated
      rotate <= (shuffleOp == OP_LOAD);
      done <= (shuffleOp == OP_UNLOAD);
    end
  end

endmodule

// File: dataShuffler.sv
`timescale 1ns/1ps

module dataShuffler import fftPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  shuffleOpT           shuffleOp,
  input  frameT               frameIn,
  input  twiddleSetT          twiddleIn,
  input  laneVecT [LANES-1:0] laneOut,
  output laneVecT [LANES-1:0] laneIn,
  output twiddleSetT          twiddles,
  output frameT               frameOut
);

  // lane operands and latched twiddles
  always_ff @(posedge clk) begin
    case (shuffleOp)
      OP_LOAD: begin
        // lane k element m takes sample k + 4m
        for (int k = 0; k < LANES; k++) begin
          for (int m = 0; m < 4; m++) begin
            laneIn[k][m] <= frameIn[k + LANES * m];
          end
        end
        twiddles <= twiddleIn;
      end
      OP_XPOSE: begin
        for (int k = 0; k < LANES; k++) begin
          for (int m = 0; m < 4; m++) begin
            laneIn[k][m] <= laneOut[m][k];
          end
        end
      end
      default: begin
      end
    endcase
  end

  // natural order output, held until the next unload
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      frameOut <= '0;
    end else if (shuffleOp == OP_UNLOAD) begin
      for (int m = 0; m < LANES; m++) begin
        for (int q = 0; q < 4; q++) begin
          frameOut[m + LANES * q] <= laneOut[m][q];
        end
      end
    end
  end

endmodule

// File: fft16Core.sv
`timescale 1ns/1ps

module fft16Core import fftPkg::*; #(
  parameter int twiddleFrac = 14
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  frameT      frameIn,
  input  twiddleSetT twiddleIn,
  output frameT      frameOut,
  output logic       done
);

  shuffleOpT shuffleOp;
  logic laneValid;
  logic rotate;
  laneVecT [LANES-1:0] laneIn;
  laneVecT [LANES-1:0] laneOut;
  twiddleSetT twiddles;
  logic [LANES-1:0] laneOutValid;

  // all lanes run in lockstep, lane 0 paces the sequencer
  stageSequencer sequencer (
    .clk(clk),
    .rst(rst),
    .start(start),
    .laneOutValid(laneOutValid[0]),
    .shuffleOp(shuffleOp),
    .laneValid(laneValid),
    .rotate(rotate),
    .done(done)
  );

  dataShuffler shuffler (
    .clk(clk),
    .rst(rst),
    .shuffleOp(shuffleOp),
    .frameIn(frameIn),
    .twiddleIn(twiddleIn),
    .laneOut(laneOut),
    .laneIn(laneIn),
    .twiddles(twiddles),
    .frameOut(frameOut)
  );

  for (genvar k = 0; k < LANES; k++) begin : laneGen
    radix4Butterfly #(
      .twiddleFrac(twiddleFrac)
    ) lane (
      .clk(clk),
      .rst(rst),
      .laneIn(laneIn[k]),
      .twiddles(twiddles[k]),
      .laneValid(laneValid),
      .rotate(rotate),
      .laneOut(laneOut[k]),
      .laneOutValid(laneOutValid[k])
    );
  end

endmodule

// File: fft16Core_assert.sv
`timescale 1ns/1ps

module fft16CoreAssert import fftPkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     done,
  input logic     laneValid,
  input logic     laneOutValid,
  input seqStateT seqState
);

  // done is a single-cycle pulse
  doneOnce: assert property (
    @(posedge clk) disable iff (!rst) done |=> !done
  ) else $error("done stayed high for a second cycle");

  // fixed two-cycle lane latency
  lanePipe: assert property (
    @(posedge clk) disable iff (!rst) laneOutValid == $past(laneValid, 2)
  ) else $error("laneOutValid does not trail laneValid by two cycles");

  idleQuiet: assert property (
    @(posedge clk) disable iff (!rst) (seqState == IDLE) |-> !laneValid
  ) else $error("laneValid raised while the sequencer is idle");

endmodule

// File: fft16Tb.sv
`timescale 1ns/1ps

module fft16Tb import fftPkg::*;;

  localparam int twiddleFrac = 14;
  localparam int doneTimeout = 20;
  localparam int doneLatency = 6;

  logic clk = 1'b0;
  logic rst;
  logic start;
  frameT frameIn;
  twiddleSetT twiddleIn;
  frameT frameOut;
  logic done;

  int errorCount;
  int checkCount;
  bit hung;
  frameT lastExpected;

  fft16Core #(
    .twiddleFrac(twiddleFrac)
  ) UUT (
    .clk(clk),
    .rst(rst),
    .start(start),
    .frameIn(frameIn),
    .twiddleIn(twiddleIn),
    .frameOut(frameOut),
    .done(done)
  );

  bind fft16Core fft16CoreAssert coreChecker (
    .clk(clk),
    .rst(rst),
    .done(done),
    .laneValid(laneValid),
    .laneOutValid(laneOutValid[0]),
    .seqState(sequencer.state)
  );

  always #50 clk = ~clk;

  // uniform samples with the signed extremes mixed in
  function automatic logic [15:0] randSample();
    logic [31:0] r;
    r = $urandom;
    case (r[2:0])
      3'd0: return 16'h8000;
      3'd1: return 16'h7fff;
      default: return r[31:16];
    endcase
  endfunction

  function automatic frameT randFrame();
    frameT f;
    for (int i = 0; i < POINTS; i++) begin
      f[i].re = randSample();
      f[i].im = randSample();
    end
    return f;
  endfunction

  function automatic twiddleSetT randTwiddles();
    twiddleSetT t;
    for (int k = 0; k < LANES; k++) begin
      for (int e = 0; e < 3; e++) begin
        t[k][e].re = randSample();
        t[k][e].im = randSample();
      end
    end
    return t;
  endfunction

  function automatic twiddleSetT unityTwiddles();
    twiddleSetT t;
    for (int k = 0; k < LANES; k++) begin
      for (int e = 0; e < 3; e++) begin
        t[k][e].re = 16'(1 << twiddleFrac);
        t[k][e].im = 16'h0000;
      end
    end
    return t;
  endfunction

  // scaled 4-point DFT where term m of output p is weighted by (-j)^(p*m)
  function automatic laneVecT dftLane(input laneVecT a);
    laneVecT y;
    int sr;
    int si;
    for (int p = 0; p < 4; p++) begin
      sr = 0;
      si = 0;
      for (int m = 0; m < 4; m++) begin
        case ((p * m) % 4)
          0: begin
            sr += a[m].re;
            si += a[m].im;
          end
          1: begin
            sr += a[m].im;
            si -= a[m].re;
          end
          2: begin
            sr -= a[m].re;
            si -= a[m].im;
          end
          default: begin
            sr -= a[m].im;
            si += a[m].re;
          end
        endcase
      end
      y[p].re = sampleT'(sr >>> 2);
      y[p].im = sampleT'(si >>> 2);
    end
    return y;
  endfunction

  function automatic complexT rotElem(input complexT a, input twiddleCplxT w);
    longint prodRe;
    longint prodIm;
    complexT y;
    prodRe = longint'(a.re) * longint'(w.re) - longint'(a.im) * longint'(w.im);
    prodIm = longint'(a.re) * longint'(w.im) + longint'(a.im) * longint'(w.re);
    y.re = sampleT'(prodRe >>> twiddleFrac);
    y.im = sampleT'(prodIm >>> twiddleFrac);
    return y;
  endfunction

  function automatic frameT modelFft(input frameT x, input twiddleSetT tw);
    laneVecT v;
    laneVecT s1 [LANES];
    laneVecT s2 [LANES];
    frameT y;
    for (int k = 0; k < LANES; k++) begin
      for (int m = 0; m < 4; m++) begin
        v[m] = x[k + 4 * m];
      end
      s1[k] = dftLane(v);
      for (int e = 1; e < 4; e++) begin
        s1[k][e] = rotElem(s1[k][e], tw[k][e-1]);
      end
    end
    // transpose and run stage two without rotation
    for (int k = 0; k < LANES; k++) begin
      for (int m = 0; m < 4; m++) begin
        v[m] = s1[m][k];
      end
      s2[k] = dftLane(v);
    end
    for (int m = 0; m < LANES; m++) begin
      for (int q = 0; q < 4; q++) begin
        y[m + 4 * q] = s2[m][q];
      end
    end
    return y;
  endfunction

  task automatic compareFrame(input frameT expected);
    for (int i = 0; i < POINTS; i++) begin
      checkCount += 2;
      if (frameOut[i].re !== expected[i].re) begin
        errorCount++;
        $display("[ERROR] %0t frameOut[%0d].re expected %0d got %0d",
                 $time, i, expected[i].re, frameOut[i].re);
      end
      if (frameOut[i].im !== expected[i].im) begin
        errorCount++;
        $display("[ERROR] %0t frameOut[%0d].im expected %0d got %0d",
                 $time, i, expected[i].im, frameOut[i].im);
      end
    end
  endtask

  task automatic checkIdle();
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      #1;
      checkCount += 2;
      if (done !== 1'b0) begin
        errorCount++;
        $display("[ERROR] %0t done expected 0 got %b", $time, done);
      end
      if (frameOut !== '0) begin
        errorCount++;
        $display("[ERROR] %0t frameOut expected 0 got %h", $time, frameOut);
      end
    end
  endtask

  // one frame where spuriousAt > 0 pulses start again that many cycles in
  task automatic runFrame(input frameT x, input twiddleSetT tw,
                          input int spuriousAt, input int quietCycles);
    frameT held;
    frameT expected;
    int cycles;
    if (hung) return;
    expected = modelFft(x, tw);
    held = lastExpected;
    @(posedge clk);
    #1;
    start = 1'b1;
    frameIn = x;
    twiddleIn = tw;
    @(posedge clk);
    #1;
    start = 1'b0;
    // inputs must have been latched at the start edge
    frameIn = randFrame();
    twiddleIn = randTwiddles();
    cycles = 0;
    while (!done && cycles < doneTimeout) begin
      @(posedge clk);
      #1;
      cycles++;
      start = (cycles == spuriousAt);
      if (!done && frameOut !== held) begin
        errorCount++;
        $display("[ERROR] %0t frameOut expected %h got %h", $time, held, frameOut);
      end
    end
    if (!done) begin
      errorCount++;
      hung = 1'b1;
      $display("timeout: done did not rise within %0d cycles of start", doneTimeout);
      return;
    end
    checkCount++;
    if (cycles != doneLatency) begin
      errorCount++;
      $display("[ERROR] %0t done latency expected %0d got %0d", $time, doneLatency, cycles);
    end
    compareFrame(expected);
    lastExpected = expected;
    for (int i = 0; i < quietCycles; i++) begin
      @(posedge clk);
      #1;
      start = 1'b0;
      checkCount += 2;
      if (done !== 1'b0) begin
        errorCount++;
        $display("[ERROR] %0t done expected 0 got %b", $time, done);
      end
      if (frameOut !== expected) begin
        errorCount++;
        $display("[ERROR] %0t frameOut expected %h got %h", $time, expected, frameOut);
      end
    end
  endtask

  initial begin
    frameT edgeFrame;
    twiddleSetT edgeTw;
    errorCount = 0;
    checkCount = 0;
    hung = 1'b0;
    lastExpected = '0;
    rst = 1'b0;
    start = 1'b0;
    frameIn = '0;
    twiddleIn = '0;
    void'($urandom(32'h58e3));
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b1;
    checkIdle();
    for (int i = 0; i < 3; i++) begin
      runFrame(randFrame(), unityTwiddles(), 0, 2);
    end
    for (int i = 0; i < 5; i++) begin
      runFrame(randFrame(), randTwiddles(), 0, 2);
    end
    // all extremes at once
    edgeFrame = {POINTS{32'h80008000}};
    edgeTw = {LANES * 3{32'h80008000}};
    runFrame(edgeFrame, edgeTw, 0, 1);
    edgeFrame = {POINTS{32'h7fff8000}};
    edgeTw = {LANES * 3{32'h7fff7fff}};
    runFrame(edgeFrame, edgeTw, 0, 1);
    // starts while busy in mid frame and in the unload cycle
    runFrame(randFrame(), randTwiddles(), 3, 8);
    runFrame(randFrame(), randTwiddles(), 6, 8);
    for (int i = 0; i < 50; i++) begin
      runFrame(randFrame(), randTwiddles(), 0, 0);
    end
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0 && !hung) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
fftPkg.sv
twiddleRotator.sv
radix4Butterfly.sv
stageSequencer.sv
dataShuffler.sv
fft16Core.sv
fft16Core_assert.sv
fft16Tb.sv

// File: runSim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fft16Tb -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vfft16Tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
echo "pass message not found"
exit 1
